//--- common/tpu_config.svh
// TPU configuration
// Data width and register file sizes shared by the package and the RTL

`ifndef TPU_CONFIG_SVH
`define TPU_CONFIG_SVH

// Width of a scalar word and of one vector element
`define TPU_DATA_W	32

// Scalar register file depth
`define TPU_SREGS	16

// Number of vector registers
`define TPU_VREGS	8

// Elements held by each vector register
`define TPU_VLEN	8

`endif

//--- common/tpu_pkg.sv
// TPU package
// Width types, opcode and sequencer encodings, and the ALU shared by both units
`include "tpu_config.svh"

package tpu_pkg;

	typedef logic [`TPU_DATA_W-1:0]			data_t;
	typedef logic [$clog2(`TPU_SREGS)-1:0]	sreg_idx_t;	// Also the width of every index field
	typedef logic [$clog2(`TPU_VREGS)-1:0]	vreg_idx_t;
	typedef logic [$clog2(`TPU_VLEN)-1:0]	elem_idx_t;
	typedef logic [$clog2(`TPU_VLEN):0]		vlen_t;		// Holds 1 to TPU_VLEN

	typedef enum logic [2:0] {
		OpAdd,
		OpSub,
		OpAnd,
		OpOr,
		OpXor,
		OpLdi	// Writes the immediate, broadcast in the vector unit
	} opcode_t;

	typedef enum logic {
		SeqIdle,
		SeqRun
	} seq_state_t;

	// One ALU evaluation, used per command in the scalar unit and per element in the vector unit
	function automatic data_t aluOp(opcode_t op, data_t a, data_t b, data_t imm);
		case (op)
			OpAdd:		return a + b;
			OpSub:		return a - b;
			OpAnd:		return a & b;
			OpOr:		return a | b;
			OpXor:		return a ^ b;
			OpLdi:		return imm;
			default:	return '0;
		endcase
	endfunction

endpackage

//--- common/commit_if.sv
// Commit interface
// One dispatched command travelling from dispatch to the scalar or the vector unit

interface commit_if;
	import tpu_pkg::*;

	logic		valid;
	logic		ready;	// Driven by the receiving unit
	opcode_t	op;
	sreg_idx_t	dst;
	sreg_idx_t	src1;
	sreg_idx_t	src2;
	data_t		imm;
	vlen_t		length;	// Only the vector unit looks at this

	modport issue (
		output	valid, op, dst, src1, src2, imm, length,
		input	ready
	);

	modport exec (
		input	valid, op, dst, src1, src2, imm, length,
		output	ready
	);

endinterface

//--- hw/dispatch/dispatch_tpu.sv
// Command dispatch
// Steers the incoming command to the scalar or vector unit and returns that unit's ready

module dispatch_tpu (
	input	logic				cmdValid,
	input	logic				cmdUnit,
	input	tpu_pkg::opcode_t	cmdOp,
	input	tpu_pkg::sreg_idx_t	cmdDst,
	input	tpu_pkg::sreg_idx_t	cmdSrc1,
	input	tpu_pkg::sreg_idx_t	cmdSrc2,
	input	tpu_pkg::data_t		cmdImm,
	input	tpu_pkg::vlen_t		cmdLength,
	output	logic				cmdReady,
	commit_if.issue				sCmd,
	commit_if.issue				vCmd
);

	logic	selVector;

	assign selVector	= cmdUnit;	// 1 picks the vector unit

	// Only the chosen side sees valid
	assign sCmd.valid	= cmdValid & ~selVector;
	assign vCmd.valid	= cmdValid &  selVector;

	// Fields fan out to both units, the idle one ignores them without valid
	assign sCmd.op		= cmdOp;
	assign sCmd.dst		= cmdDst;
	assign sCmd.src1	= cmdSrc1;
	assign sCmd.src2	= cmdSrc2;
	assign sCmd.imm		= cmdImm;
	assign sCmd.length	= cmdLength;

	assign vCmd.op		= cmdOp;
	assign vCmd.dst		= cmdDst;
	assign vCmd.src1	= cmdSrc1;
	assign vCmd.src2	= cmdSrc2;
	assign vCmd.imm		= cmdImm;
	assign vCmd.length	= cmdLength;

	// A vector command stalls here while the sequencer is busy
	assign cmdReady		= selVector ? vCmd.ready : sCmd.ready;

endmodule

//--- hw/scalar/scalar_unit.sv
// Scalar unit
// Sixteen-entry register file with a single-cycle ALU and a registered writeback port
`include "tpu_config.svh"

module scalar_unit (
	input	logic				clock,
	input	logic				rstN,
	commit_if.exec				cmd,
	output	logic				wbValid,
	output	tpu_pkg::sreg_idx_t	wbDst,
	output	tpu_pkg::data_t		wbData
);
	import tpu_pkg::*;

	data_t	regFile [`TPU_SREGS];
	data_t	opA;
	data_t	opB;
	data_t	result;
	logic	fire;

	// Finishes one command per cycle, so it never pushes back
	assign cmd.ready	= 1'b1;
	assign fire			= cmd.valid & cmd.ready;

	// Operands come from the register state before the accepting edge
	assign opA			= regFile[cmd.src1];
	assign opB			= regFile[cmd.src2];
	assign result		= aluOp(cmd.op, opA, opB, cmd.imm);

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `TPU_SREGS; i++) begin
				regFile[i] <= '0;
			end
		end else if (fire) begin
			regFile[cmd.dst] <= result;
		end
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= fire;	// High for the cycle after acceptance
		end
	end

	// Writeback fields are captured on the same edge as the register write
	always_ff @(posedge clock) begin
		if (fire) begin
			wbDst	<= cmd.dst;
			wbData	<= result;
		end
	end

endmodule

//--- hw/vector/vector_seq.sv
// Vector sequencer
// Accepts one vector command, steps through its elements and returns to idle

module vector_seq (
	input	logic	clock,
	input	logic	rstN,
	commit_if.exec	cmd,
	input	logic	last,
	output	logic	start,
	output	logic	run,
	output	logic	clear
);
	import tpu_pkg::*;

	seq_state_t	state;
	seq_state_t	stateNext;
	logic		accept;

	// New commands are taken only between runs
	assign cmd.ready	= (state == SeqIdle);
	assign accept		= cmd.valid & cmd.ready;

	assign start		= accept;	// Lane latches the command fields
	assign clear		= accept;	// Counter restarts at element zero
	assign run			= (state == SeqRun);

	always_comb begin
		stateNext = state;
		case (state)
			SeqIdle: begin
				if (accept) begin
					stateNext = SeqRun;
				end
			end
			SeqRun: begin
				// Leave on the edge that runs the final element
				if (last) begin
					stateNext = SeqIdle;
				end
			end
			default: begin
				stateNext = SeqIdle;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= SeqIdle;
		end else begin
			state <= stateNext;
		end
	end

endmodule

//--- hw/vector/element_counter.sv
// Element counter
// Walks the element index of a vector run and flags the final element

module element_counter (
	input	logic					clock,
	input	logic					rstN,
	input	logic					clear,
	input	logic					step,
	input	tpu_pkg::vlen_t			length,
	output	tpu_pkg::elem_idx_t		index,
	output	logic					last
);
	import tpu_pkg::*;

	vlen_t	lengthReg;	// Length of the run in progress
	vlen_t	lastIndex;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			index		<= '0;
			lengthReg	<= '0;
		end else if (clear) begin
			index		<= '0;
			lengthReg	<= length;
		end else if (step) begin
			index		<= index + 1'b1;
		end
	end

	assign lastIndex	= lengthReg - 1'b1;
	assign last			= ({1'b0, index} == lastIndex);

endmodule

//--- hw/vector/vector_lane.sv
// Vector lane
// Vector register file, element ALU and the element writeback register
`include "tpu_config.svh"

module vector_lane (
	input	logic					clock,
	input	logic					rstN,
	input	logic					start,
	input	logic					run,
	commit_if.exec					cmd,
	input	tpu_pkg::elem_idx_t		index,
	output	logic					wbValid,
	output	tpu_pkg::vreg_idx_t		wbReg,
	output	tpu_pkg::elem_idx_t		wbElem,
	output	tpu_pkg::data_t			wbData
);
	import tpu_pkg::*;

	data_t		vecRegs [`TPU_VREGS][`TPU_VLEN];
	opcode_t	opReg;
	vreg_idx_t	dstReg;
	vreg_idx_t	src1Reg;
	vreg_idx_t	src2Reg;
	data_t		immReg;
	data_t		elemA;
	data_t		elemB;
	data_t		result;

	// Command fields held for the whole run, only the low index bits matter here
	always_ff @(posedge clock) begin
		if (start) begin
			opReg	<= cmd.op;
			dstReg	<= vreg_idx_t'(cmd.dst);
			src1Reg	<= vreg_idx_t'(cmd.src1);
			src2Reg	<= vreg_idx_t'(cmd.src2);
			immReg	<= cmd.imm;
		end
	end

	assign elemA	= vecRegs[src1Reg][index];
	assign elemB	= vecRegs[src2Reg][index];
	assign result	= aluOp(opReg, elemA, elemB, immReg);	// OpLdi broadcasts the immediate

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int r = 0; r < `TPU_VREGS; r++) begin
				for (int e = 0; e < `TPU_VLEN; e++) begin
					vecRegs[r][e] <= '0;
				end
			end
		end else if (run) begin
			vecRegs[dstReg][index] <= result;
		end
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= run;
		end
	end

	// One writeback per element, in index order
	always_ff @(posedge clock) begin
		if (run) begin
			wbReg	<= dstReg;
			wbElem	<= index;
			wbData	<= result;
		end
	end

endmodule

//--- hw/tpu_top.sv
// TPU issue stage
// Dispatch feeding a scalar unit and a sequenced vector unit, each with its own writeback port

module tpu_top (
	input	logic					clock,
	input	logic					rstN,
	input	logic					cmdValid,
	input	logic					cmdUnit,
	input	tpu_pkg::opcode_t		cmdOp,
	input	tpu_pkg::sreg_idx_t		cmdDst,
	input	tpu_pkg::sreg_idx_t		cmdSrc1,
	input	tpu_pkg::sreg_idx_t		cmdSrc2,
	input	tpu_pkg::data_t			cmdImm,
	input	tpu_pkg::vlen_t			cmdLength,
	output	logic					cmdReady,
	output	logic					sWbValid,
	output	tpu_pkg::sreg_idx_t		sWbDst,
	output	tpu_pkg::data_t			sWbData,
	output	logic					vWbValid,
	output	tpu_pkg::vreg_idx_t		vWbReg,
	output	tpu_pkg::elem_idx_t		vWbElem,
	output	tpu_pkg::data_t			vWbData
);
	import tpu_pkg::*;

	commit_if	sCmd ();
	commit_if	vCmd ();

	logic		seqStart;
	logic		seqRun;
	logic		seqClear;
	logic		elemLast;
	elem_idx_t	elemIndex;

	dispatch_tpu uDispatch (
		.cmdValid	(cmdValid),
		.cmdUnit	(cmdUnit),
		.cmdOp		(cmdOp),
		.cmdDst		(cmdDst),
		.cmdSrc1	(cmdSrc1),
		.cmdSrc2	(cmdSrc2),
		.cmdImm		(cmdImm),
		.cmdLength	(cmdLength),
		.cmdReady	(cmdReady),
		.sCmd		(sCmd.issue),
		.vCmd		(vCmd.issue)
	);

	scalar_unit uScalar (
		.clock		(clock),
		.rstN		(rstN),
		.cmd		(sCmd.exec),
		.wbValid	(sWbValid),
		.wbDst		(sWbDst),
		.wbData		(sWbData)
	);

	vector_seq uSeq (
		.clock		(clock),
		.rstN		(rstN),
		.cmd		(vCmd.exec),
		.last		(elemLast),
		.start		(seqStart),
		.run		(seqRun),
		.clear		(seqClear)
	);

	// Each run cycle consumes one element
	element_counter uCounter (
		.clock		(clock),
		.rstN		(rstN),
		.clear		(seqClear),
		.step		(seqRun),
		.length		(vCmd.length),
		.index		(elemIndex),
		.last		(elemLast)
	);

	vector_lane uLane (
		.clock		(clock),
		.rstN		(rstN),
		.start		(seqStart),
		.run		(seqRun),
		.cmd		(vCmd.exec),
		.index		(elemIndex),
		.wbValid	(vWbValid),
		.wbReg		(vWbReg),
		.wbElem		(vWbElem),
		.wbData		(vWbData)
	);

endmodule

//--- tb/tb_clock.sv
// Testbench clock and reset
// Free-running clock with rstN held low for the first few cycles

module tb_clock #(
	parameter int Period		= 100,
	parameter int ResetCycles	= 3
) (
	output	logic	clock,
	output	logic	rstN
);

	initial begin
		clock = 1'b0;
		forever #(Period / 2) clock = ~clock;
	end

	initial begin
		rstN = 1'b0;
		repeat (ResetCycles) @(posedge clock);
		#10 rstN = 1'b1;	// Released just after an edge, like every other input
	end

endmodule

//--- tb/tb_tpu.sv
// TPU issue stage testbench
// Drives commands into tpu_top, models both register files and checks every writeback
`include "tpu_config.svh"

module tb_tpu;
	import tpu_pkg::*;

	localparam int ClkPeriod	= 100;
	localparam int NumRandom	= 200;
	localparam int NumCmds		= 8 + 18 + 6 + 14 + NumRandom;	// Commands over all tests

	typedef struct packed {
		sreg_idx_t	dst;
		data_t		data;
		int			cycle;
	} scalarWb_t;

	typedef struct packed {
		vreg_idx_t	vreg;
		elem_idx_t	elem;
		data_t		data;
		int			cycle;
	} vectorWb_t;

	logic		clock;
	logic		rstN;
	logic		cmdValid;
	logic		cmdUnit;
	opcode_t	cmdOp;
	sreg_idx_t	cmdDst;
	sreg_idx_t	cmdSrc1;
	sreg_idx_t	cmdSrc2;
	data_t		cmdImm;
	vlen_t		cmdLength;
	logic		cmdReady;
	logic		sWbValid;
	sreg_idx_t	sWbDst;
	data_t		sWbData;
	logic		vWbValid;
	vreg_idx_t	vWbReg;
	elem_idx_t	vWbElem;
	data_t		vWbData;

	data_t			sShadow [`TPU_SREGS];
	data_t			vShadow [`TPU_VREGS][`TPU_VLEN];
	scalarWb_t		sQueue [$];
	vectorWb_t		vQueue [$];
	logic [31:0]	rngState	= 32'h2862;
	int				cycleCount	= 0;	// Number of rising edges seen
	int				errorCount	= 0;
	int				checkCount	= 0;
	int				testCount	= 0;
	int				testErrors	= 0;

	tb_clock #(.Period(ClkPeriod), .ResetCycles(3)) uClock (.clock(clock), .rstN(rstN));

	tpu_top u_dut (.*);

	always @(posedge clock) cycleCount <= cycleCount + 1;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function logic [31:0] randWord();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	// Expected result of one opcode from its arithmetic or bitwise meaning
	function automatic data_t refResult(opcode_t op, data_t a, data_t b, data_t imm);
		data_t value;
		value = '0;
		if (op == OpLdi) begin
			value = imm;
		end else if (op == OpAdd) begin
			value = a + b;
		end else if (op == OpSub) begin
			value = a + ~b + 1'b1;	// Adds the two's complement of b
		end else if (op == OpAnd) begin
			value = a & b;
		end else if (op == OpOr) begin
			value = a | b;
		end else if (op == OpXor) begin
			value = (a | b) & ~(a & b);	// Bits set in exactly one operand
		end
		return value;
	endfunction

	// Updates the shadow registers and queues the writebacks an accepted command must produce
	task automatic recordCmd(input logic unit, input opcode_t op, input sreg_idx_t dst,
			input sreg_idx_t src1, input sreg_idx_t src2, input data_t imm, input vlen_t len,
			input int accept);
		vreg_idx_t	d;
		vreg_idx_t	a;
		vreg_idx_t	b;
		data_t		value;
		d = dst[2:0];	// The vector unit only sees the low index bits
		a = src1[2:0];
		b = src2[2:0];
		if (!unit) begin
			value = refResult(op, sShadow[src1], sShadow[src2], imm);
			sShadow[dst] = value;
			sQueue.push_back('{dst, value, accept});
		end else begin
			for (int i = 0; i < len; i++) begin
				value = refResult(op, vShadow[a][i], vShadow[b][i], imm);
				vShadow[d][i] = value;
				vQueue.push_back('{d, elem_idx_t'(i), value, accept + 1 + i});
			end
		end
	endtask

	// Holds a command on the port until it transfers and returns the edge and the stall count
	task automatic issueCmd(input logic unit, input opcode_t op, input sreg_idx_t dst,
			input sreg_idx_t src1, input sreg_idx_t src2, input data_t imm, input vlen_t len,
			output int accept, output int stalls);
		cmdValid	= 1'b1;
		cmdUnit		= unit;
		cmdOp		= op;
		cmdDst		= dst;
		cmdSrc1		= src1;
		cmdSrc2		= src2;
		cmdImm		= imm;
		cmdLength	= len;
		stalls		= 0;
		@(negedge clock);
		while (!cmdReady) begin
			stalls++;
			@(negedge clock);
		end
		accept = cycleCount + 1;	// Transfer on the coming rising edge
		recordCmd(unit, op, dst, src1, src2, imm, len, accept);
		@(posedge clock);
		#10;
	endtask

	// Lets outstanding writebacks drain and reports the test
	task automatic finishTest(input string name);
		int waitCycles;
		cmdValid	= 1'b0;
		waitCycles	= 0;
		while ((sQueue.size() != 0 || vQueue.size() != 0) && waitCycles < `TPU_VLEN + 4) begin
			@(posedge clock);
			waitCycles++;
		end
		assert (sQueue.size() == 0 && vQueue.size() == 0) else begin
			$display("%0d scalar and %0d vector writebacks were expected but never arrived",
				sQueue.size(), vQueue.size());
			errorCount++;
			sQueue.delete();
			vQueue.delete();
		end
		testCount++;
		$display("test %0d %s done with %0d errors", testCount, name, errorCount - testErrors);
		testErrors = errorCount;
		@(posedge clock);
		#10;
	endtask

	// Every writeback is held against the oldest expected entry of its port
	always @(negedge clock) begin
		scalarWb_t	sExp;
		vectorWb_t	vExp;
		if (rstN && sWbValid) begin
			checkCount++;
			if (sQueue.size() == 0) begin
				$display("Unexpected scalar writeback to r%0d at time %0t", sWbDst, $time);
				errorCount++;
			end else begin
				sExp = sQueue.pop_front();
				assert (sWbDst == sExp.dst && sWbData == sExp.data && cycleCount == sExp.cycle)
				else begin
					$display("[FAIL] %0t: scalar r%0d=%h in %0d, expected r%0d=%h in %0d",
						$time, sWbDst, sWbData, cycleCount, sExp.dst, sExp.data, sExp.cycle);
					errorCount++;
				end
			end
		end
		if (rstN && vWbValid) begin
			checkCount++;
			if (vQueue.size() == 0) begin
				$display("Unexpected vector writeback to v%0d at time %0t", vWbReg, $time);
				errorCount++;
			end else begin
				vExp = vQueue.pop_front();
				assert (vWbReg == vExp.vreg && vWbElem == vExp.elem && vWbData == vExp.data
						&& cycleCount == vExp.cycle)
				else begin
					$display("[FAIL] %0t: vector v%0d[%0d]=%h in %0d, expected v%0d[%0d]=%h in %0d",
						$time, vWbReg, vWbElem, vWbData, cycleCount,
						vExp.vreg, vExp.elem, vExp.data, vExp.cycle);
					errorCount++;
				end
			end
		end
	end

	initial begin
		int				acc;
		int				stalls;
		int				first;
		int				holdLen;
		logic [31:0]	r;
		cmdValid	= 1'b0;
		cmdUnit		= 1'b0;
		cmdOp		= OpAdd;
		cmdDst		= '0;
		cmdSrc1		= '0;
		cmdSrc2		= '0;
		cmdImm		= '0;
		cmdLength	= 1;
		foreach (sShadow[i]) sShadow[i] = '0;
		foreach (vShadow[i, j]) vShadow[i][j] = '0;

		wait (rstN === 1'b1);
		@(posedge clock);
		#10;
		repeat (2) begin
			@(negedge clock);
			checkCount++;
			assert (!sWbValid && !vWbValid && cmdReady) else begin
				$display("[FAIL] %0t: after reset sWbValid=%b vWbValid=%b cmdReady=%b",
					$time, sWbValid, vWbValid, cmdReady);
				errorCount++;
			end
			@(posedge clock);
			#10;
			cmdUnit = ~cmdUnit;	// Second pass looks at the vector side's ready
		end
		finishTest("reset");

		issueCmd(0, OpLdi, 1, 0, 0, randWord(), 1, first, stalls);
		issueCmd(0, OpLdi, 2, 0, 0, randWord(), 1, acc, stalls);
		for (int k = 0; k < 5; k++) begin
			issueCmd(0, opcode_t'(k), sreg_idx_t'(3 + k), 1, 2, randWord(), 1, acc, stalls);
		end
		issueCmd(0, OpAdd, 8, 3, 4, 0, 1, acc, stalls);	// Reads results written just before
		checkCount++;
		assert (acc == first + 7) else begin
			$display("[FAIL] %0t: scalar commands not accepted back to back", $time);
			errorCount++;
		end
		finishTest("scalar ops");

		issueCmd(1, OpLdi, 1, 0, 0, randWord(), 8, acc, stalls);
		issueCmd(1, OpLdi, 2, 0, 0, randWord(), 8, acc, stalls);
		for (int len = 1; len <= `TPU_VLEN; len++) begin
			issueCmd(1, OpLdi, 0, 0, 0, randWord(), vlen_t'(len), acc, stalls);
			// Destination has bit 3 set, which the vector unit must drop
			issueCmd(1, opcode_t'((len - 1) % 5), sreg_idx_t'(11 + len % 5), 1,
				sreg_idx_t'(2 * (len % 2)), 0, vlen_t'(len), acc, stalls);
		end
		finishTest("vector ops");

		for (int k = 0; k < 3; k++) begin
			holdLen = (k == 0) ? 8 : (k == 1) ? 3 : 1;
			issueCmd(1, OpAdd, 3, 1, 2, 0, vlen_t'(holdLen), first, stalls);
			issueCmd(1, OpXor, 4, 3, 1, 0, 5, acc, stalls);
			checkCount++;
			assert (stalls == holdLen && acc == first + holdLen + 1) else begin
				$display("[FAIL] %0t: held command taken in %0d after %0d stalls, expected %0d",
					$time, acc, stalls, first + holdLen + 1);
				errorCount++;
			end
		end
		finishTest("back-pressure");

		for (int k = 0; k < 2; k++) begin
			issueCmd(1, OpSub, 5, 4, 3, 0, 8, first, stalls);
			for (int j = 0; j < 6; j++) begin
				r = randWord();
				issueCmd(0, opcode_t'(r[31:8] % 6), r[3:0], r[7:4], r[11:8], randWord(), 1,
					acc, stalls);
				checkCount++;
				assert (stalls == 0 && acc == first + 1 + j) else begin
					$display("[FAIL] %0t: scalar command taken in cycle %0d after %0d stalls",
						$time, acc, stalls);
					errorCount++;
				end
			end
		end
		finishTest("overlap");

		for (int k = 0; k < NumRandom; k++) begin
			r = randWord();
			issueCmd(r[0], opcode_t'(r[31:16] % 6), r[7:4], r[11:8], r[15:12], randWord(),
				vlen_t'(1 + r[30:28]), acc, stalls);
			if (r[2:1] == 2'b00) begin
				cmdValid = 1'b0;	// Occasional idle cycle on the port
				@(posedge clock);
				#10;
			end
		end
		finishTest("random mix");

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// Each command can hold the port for at most a full vector run plus a little
	initial begin
		repeat (NumCmds * (`TPU_VLEN + 2) + 100) @(posedge clock);
		$display("The run timed out at %0t before all tests finished", $time);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- tb.f
+incdir+common
common/tpu_pkg.sv
common/commit_if.sv
hw/dispatch/dispatch_tpu.sv
hw/scalar/scalar_unit.sv
hw/vector/vector_seq.sv
hw/vector/element_counter.sv
hw/vector/vector_lane.sv
hw/tpu_top.sv
tb/tb_clock.sv
tb/tb_tpu.sv

//--- Bender.yml
package:
  name: tpu_issue

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/tpu_pkg.sv
      - common/commit_if.sv
      - hw/dispatch/dispatch_tpu.sv
      - hw/scalar/scalar_unit.sv
      - hw/vector/vector_seq.sv
      - hw/vector/element_counter.sv
      - hw/vector/vector_lane.sv
      - hw/tpu_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_clock.sv
      - tb/tb_tpu.sv
